//--- rob.f
design/rob_pkg.sv
design/fetch_ctrl.sv
design/rob_store.sv
design/commit_unit.sv
design/rob_top.sv
verification/rob_chk.sv
verification/rob_tb.sv

//--- Makefile
VERILATOR  = verilator
TOP        = rob_tb
FILELIST   = rob.f
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
LOG        = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- verification/rob_tb.sv
`timescale 1ns/100ps

module rob_tb import rob_pkg::*; ();

  localparam int    DEPTH      = 8;
  // five tests of a few hundred cycles each plus wide margin
  localparam int    MAX_CYCLES = 3000;
  localparam addr_t START_PC   = 32'h0000_0100;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic        fetch_req;
  logic        fetch_valid = 1'b0;
  word_t       fetch_instr = '0;
  addr_t       fetch_pc = '0;
  logic        dec_req;
  word_t       dec_instr;
  logic        dec_valid = 1'b0;
  dec_resp_t   dec_resp = '0;
  logic        pc_write;
  addr_t       pc_next;
  issue_t      issue;
  wb_t         wb = '0;
  reg_commit_t reg_commit;
  mem_store_t  mem_store;
  logic        store_done = 1'b0;
  logic        flush;
  addr_t       flush_pc;

  integer      seed = 32'h67d5_2b3e;
  int          cyc = 0;
  int          freq_cnt = 0;
  int          f_wait = 0;
  int          d_wait = 0;
  int          s_wait = 0;
  logic        auto_wb = 1'b0;
  addr_t       pc_model = START_PC;
  // instruction table indexed by pc[7:2]
  dec_resp_t   prog [64];

  issue_t      issue_q [$];
  addr_t       pcw_q [$];
  reg_commit_t commit_q [$];
  mem_store_t  store_q [$];
  addr_t       flush_q [$];
  int          store_cyc_q [$];
  int          done_cyc_q [$];
  int          commit_cyc_q [$];
  wb_t         wb_pend [$];

  rob_top #(
    .DEPTH (DEPTH)
  ) dut0 (.*);

  initial begin
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= MAX_CYCLES) begin
      fail_run("timeout, the run went past the cycle limit");
    end
  end

  // fetch, decode and memory models
  always @(negedge clk) begin
    fetch_valid <= 1'b0;
    dec_valid   <= 1'b0;
    store_done  <= 1'b0;
    if (rst) begin
      f_wait   = 0;
      d_wait   = 0;
      s_wait   = 0;
      pc_model = START_PC;
    end else begin
      if (pc_write) begin
        pc_model = pc_next;
      end
      if (flush) begin
        // requests in flight are dropped
        pc_model = flush_pc;
        f_wait   = 0;
        d_wait   = 0;
      end else begin
        if (fetch_req) begin
          f_wait = 1 + int'($unsigned($random(seed)) % 3);
        end else if (f_wait > 0) begin
          f_wait--;
          if (f_wait == 0) begin
            fetch_valid <= 1'b1;
            fetch_instr <= pc_model;
            fetch_pc    <= pc_model;
          end
        end
        if (dec_req) begin
          d_wait = 1 + int'($unsigned($random(seed)) % 3);
        end else if (d_wait > 0) begin
          d_wait--;
          if (d_wait == 0) begin
            dec_valid <= 1'b1;
            dec_resp  <= prog[dec_instr[7:2]];
          end
        end
      end
      // slower memory so the store wait is visible
      if (mem_store.valid) begin
        s_wait = 4 + int'($unsigned($random(seed)) % 4);
      end else if (s_wait > 0) begin
        s_wait--;
        if (s_wait == 0) begin
          store_done <= 1'b1;
        end
      end
    end
  end

  // output monitor and writeback driver
  always @(negedge clk) begin
    wb <= '0;
    if (rst) begin
      issue_q.delete();
      pcw_q.delete();
      commit_q.delete();
      store_q.delete();
      flush_q.delete();
      store_cyc_q.delete();
      done_cyc_q.delete();
      commit_cyc_q.delete();
      wb_pend.delete();
      freq_cnt = 0;
    end else begin
      if (fetch_req) begin
        freq_cnt++;
      end
      if (issue.valid) begin
        issue_q.push_back(issue);
        if (auto_wb) begin
          wb_pend.push_back(make_wb(issue.tag, 32'd1, 32'h200));
        end
      end
      if (pc_write) begin
        pcw_q.push_back(pc_next);
      end
      if (reg_commit.valid) begin
        commit_q.push_back(reg_commit);
        commit_cyc_q.push_back(cyc);
      end
      if (mem_store.valid) begin
        store_q.push_back(mem_store);
        store_cyc_q.push_back(cyc);
      end
      if (store_done) begin
        done_cyc_q.push_back(cyc);
      end
      if (flush) begin
        flush_q.push_back(flush_pc);
      end
      if (wb_pend.size() > 0) begin
        wb <= wb_pend.pop_front();
      end
    end
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check(input word_t got, input word_t exp, input string msg);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH at %0t: %s, got %h expected %h", $time, msg, got, exp));
    end
  endtask

  function automatic dec_resp_t make_resp(op_class_t cls, reg_idx_t rd, func3_t f3,
                                          word_t imm);
    dec_resp_t r;
    r.cls   = cls;
    r.rd    = rd;
    r.func3 = f3;
    r.imm   = imm;
    return r;
  endfunction

  function automatic wb_t make_wb(tag_t tag, word_t result, addr_t tar);
    wb_t w;
    w.valid    = 1'b1;
    w.tag      = tag;
    w.result   = result;
    w.tar_addr = tar;
    return w;
  endfunction

  task automatic load_default_prog();
    for (int i = 0; i < 64; i++) begin
      prog[i] = make_resp(op_alu, reg_idx_t'(i % 31 + 1), 3'd0, 32'd0);
    end
  endtask

  task automatic apply_reset();
    rst <= 1'b1;
    repeat (5) @(negedge clk);
    rst <= 1'b0;
  endtask

  task automatic next_pc_and_tags();
    addr_t     pc;
    addr_t     nxt;
    issue_t    it;
    dec_resp_t r;
    load_default_prog();
    prog[1] = make_resp(op_jal, 5'd2, 3'd0, 32'd16);
    prog[3] = make_resp(op_load, 5'd3, 3'd2, 32'd0);
    prog[4] = make_resp(op_store, 5'd0, 3'd2, 32'd0);
    prog[5] = make_resp(op_branch, 5'd0, 3'd0, 32'hffff_fff8);
    auto_wb = 1'b1;
    apply_reset();
    while (issue_q.size() < 12) @(negedge clk);
    auto_wb = 1'b0;
    pc = START_PC;
    for (int i = 0; i < 12; i++) begin
      it  = issue_q[i];
      r   = prog[pc[7:2]];
      // static taken for jal and branch
      nxt = (r.cls == op_jal || r.cls == op_branch) ? pc + r.imm : pc + 32'd4;
      check(32'(it.tag), 32'(i % DEPTH), "issue tag");
      check(it.pc, pc, "issue pc");
      check(32'(it.cls), 32'(r.cls), "issue class");
      check(32'(it.rd), 32'(r.rd), "issue rd");
      check(pcw_q[i], nxt, "pc_write value");
      pc = nxt;
    end
  endtask

  task automatic in_order_commit();
    reg_commit_t c;
    load_default_prog();
    prog[0] = make_resp(op_alu, 5'd5, 3'd0, 32'd0);
    prog[1] = make_resp(op_alu, 5'd0, 3'd0, 32'd0);
    prog[2] = make_resp(op_alu, 5'd6, 3'd0, 32'd0);
    apply_reset();
    while (issue_q.size() < 3) @(negedge clk);
    wb_pend.push_back(make_wb(4'd2, 32'h0000_00c2, 32'd0));
    wb_pend.push_back(make_wb(4'd1, 32'h0000_00b1, 32'd0));
    wb_pend.push_back(make_wb(4'd0, 32'h0000_00a0, 32'd0));
    while (commit_q.size() < 2) @(negedge clk);
    repeat (10) @(negedge clk);
    check(commit_q.size(), 32'd2, "register commit count");
    c = commit_q[0];
    check(32'(c.rd), 32'd5, "first commit rd");
    check(32'(c.tag), 32'd0, "first commit tag");
    check(c.value, 32'h0000_00a0, "first commit value");
    c = commit_q[1];
    check(32'(c.rd), 32'd6, "second commit rd");
    check(32'(c.tag), 32'd2, "second commit tag");
    check(c.value, 32'h0000_00c2, "second commit value");
  endtask

  task automatic store_commit();
    mem_len_t    exp_len [3];
    mem_store_t  s;
    reg_commit_t c;
    exp_len = '{2'd0, 2'd1, 2'd3};
    load_default_prog();
    for (int i = 0; i < 3; i++) begin
      prog[i] = make_resp(op_store, 5'd0, func3_t'(i), 32'd0);
    end
    prog[3] = make_resp(op_alu, 5'd9, 3'd0, 32'd0);
    apply_reset();
    while (issue_q.size() < 4) @(negedge clk);
    for (int i = 0; i < 4; i++) begin
      wb_pend.push_back(make_wb(tag_t'(i), 32'h1000 + i, 32'h300 + 4 * i));
    end
    while (commit_q.size() < 1) @(negedge clk);
    check(store_q.size(), 32'd3, "store count");
    check(done_cyc_q.size(), 32'd3, "store_done count before the alu commit");
    for (int i = 0; i < 3; i++) begin
      s = store_q[i];
      check(s.addr, 32'h300 + 4 * i, "store address");
      check(s.data, 32'h1000 + i, "store data");
      check(32'(s.len), 32'(exp_len[i]), "store length");
    end
    for (int i = 0; i < 2; i++) begin
      check(32'(store_cyc_q[i + 1] > done_cyc_q[i]), 32'd1, "store before store_done");
    end
    check(32'(commit_cyc_q[0] > done_cyc_q[2]), 32'd1, "commit during store wait");
    c = commit_q[0];
    check(32'(c.rd), 32'd9, "alu commit rd");
    check(32'(c.tag), 32'd3, "alu commit tag");
    check(c.value, 32'h1003, "alu commit value");
  endtask

  task automatic branch_and_jalr();
    issue_t      it;
    reg_commit_t c;
    load_default_prog();
    prog[0] = make_resp(op_branch, 5'd0, 3'd0, 32'd12);
    prog[3] = make_resp(op_branch, 5'd0, 3'd1, 32'd8);
    prog[4] = make_resp(op_jalr, 5'd10, 3'd0, 32'd0);
    apply_reset();
    while (issue_q.size() < 2) @(negedge clk);
    it = issue_q[1];
    check(it.pc, 32'h10c, "predicted branch target");
    // first branch taken and second not taken
    wb_pend.push_back(make_wb(4'd0, 32'd1, 32'd0));
    wb_pend.push_back(make_wb(4'd1, 32'd0, 32'd0));
    while (flush_q.size() < 1) @(negedge clk);
    issue_q.delete();
    check(flush_q[0], 32'h110, "branch flush pc");
    while (issue_q.size() < 1) @(negedge clk);
    it = issue_q[0];
    check(32'(it.tag), 32'd0, "tag after branch flush");
    check(it.pc, 32'h110, "pc after branch flush");
    check(32'(it.cls), 32'(op_jalr), "class after branch flush");
    wb_pend.push_back(make_wb(4'd0, 32'h55, 32'h140));
    while (flush_q.size() < 2) @(negedge clk);
    issue_q.delete();
    check(flush_q[1], 32'h140, "jalr flush pc");
    while (issue_q.size() < 1) @(negedge clk);
    it = issue_q[0];
    check(32'(it.tag), 32'd0, "tag after jalr flush");
    check(it.pc, 32'h140, "pc after jalr flush");
    check(commit_q.size(), 32'd1, "jalr register commit count");
    c = commit_q[0];
    check(32'(c.rd), 32'd10, "jalr commit rd");
    check(32'(c.tag), 32'd0, "jalr commit tag");
    check(c.value, 32'h55, "jalr commit value");
  endtask

  task automatic full_queue();
    issue_t it;
    load_default_prog();
    apply_reset();
    while (issue_q.size() < DEPTH - 1) @(negedge clk);
    // long enough for several more fetches
    repeat (30) @(negedge clk);
    check(issue_q.size(), DEPTH - 1, "issues into a full queue");
    check(freq_cnt, DEPTH - 1, "fetch requests into a full queue");
    wb_pend.push_back(make_wb(4'd0, 32'd7, 32'd0));
    while (issue_q.size() < DEPTH) @(negedge clk);
    it = issue_q[DEPTH - 1];
    check(32'(it.tag), DEPTH - 1, "tag after one commit");
  endtask

  initial begin
    next_pc_and_tags();
    in_order_commit();
    store_commit();
    branch_and_jalr();
    full_queue();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- verification/rob_chk.sv
`timescale 1ns/100ps

module rob_chk import rob_pkg::*; (
  input logic       clk,
  input logic       rst,
  input logic       flush,
  input logic       fetch_req,
  input logic       fetch_valid,
  input mem_store_t mem_store,
  input logic       store_done
);

  logic fetch_open;
  logic store_open;

  // outstanding requests, a flush drops the fetch
  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_open <= 1'b0;
      store_open <= 1'b0;
    end else begin
      if (flush) begin
        fetch_open <= 1'b0;
      end else if (fetch_req) begin
        fetch_open <= 1'b1;
      end else if (fetch_valid) begin
        fetch_open <= 1'b0;
      end
      if (mem_store.valid) begin
        store_open <= 1'b1;
      end else if (store_done) begin
        store_open <= 1'b0;
      end
    end
  end

  flush_one_cycle: assert property (@(posedge clk) disable iff (rst) flush |=> !flush)
    else $error("flush held for more than one cycle");

  store_waits_done: assert property (@(posedge clk) disable iff (rst)
    mem_store.valid |-> !store_open)
    else $error("second store issued before store_done");

  fetch_one_open: assert property (@(posedge clk) disable iff (rst)
    fetch_req |-> !fetch_open)
    else $error("fetch_req raised while a fetch is outstanding");

endmodule

bind rob_top rob_chk chk0 (
  .clk         (clk),
  .rst         (rst),
  .flush       (flush),
  .fetch_req   (fetch_req),
  .fetch_valid (fetch_valid),
  .mem_store   (mem_store),
  .store_done  (store_done)
);

//--- design/rob_top.sv
`timescale 1ns/100ps

module rob_top import rob_pkg::*; #(
  parameter int DEPTH = 8
) (
  input  logic        clk,
  input  logic        rst,
  // fetch
  output logic        fetch_req,
  input  logic        fetch_valid,
  input  word_t       fetch_instr,
  input  addr_t       fetch_pc,
  // decode
  output logic        dec_req,
  output word_t       dec_instr,
  input  logic        dec_valid,
  input  dec_resp_t   dec_resp,
  // pc update
  output logic        pc_write,
  output addr_t       pc_next,
  // execution side
  output issue_t      issue,
  input  wb_t         wb,
  output reg_commit_t reg_commit,
  // memory
  output mem_store_t  mem_store,
  input  logic        store_done,
  // redirect
  output logic        flush,
  output addr_t       flush_pc
);

  logic       has_room;
  logic       alloc_valid;
  rob_entry_t alloc_entry;
  logic       head_valid;
  tag_t       head_tag;
  rob_entry_t head_entry;
  logic       pop;

  fetch_ctrl fetch_ctrl0 (
    .clk         (clk),
    .rst         (rst),
    .has_room    (has_room),
    .flush       (flush),
    .fetch_valid (fetch_valid),
    .fetch_instr (fetch_instr),
    .fetch_pc    (fetch_pc),
    .dec_valid   (dec_valid),
    .dec_resp    (dec_resp),
    .fetch_req   (fetch_req),
    .dec_req     (dec_req),
    .dec_instr   (dec_instr),
    .pc_write    (pc_write),
    .pc_next     (pc_next),
    .alloc_valid (alloc_valid),
    .alloc_entry (alloc_entry)
  );

  rob_store #(
    .DEPTH (DEPTH)
  ) rob_store0 (
    .clk         (clk),
    .rst         (rst),
    .alloc_valid (alloc_valid),
    .alloc_entry (alloc_entry),
    .wb          (wb),
    .pop         (pop),
    .flush       (flush),
    .has_room    (has_room),
    .issue       (issue),
    .head_valid  (head_valid),
    .head_tag    (head_tag),
    .head_entry  (head_entry)
  );

  commit_unit commit_unit0 (
    .clk        (clk),
    .rst        (rst),
    .head_valid (head_valid),
    .head_tag   (head_tag),
    .head_entry (head_entry),
    .store_done (store_done),
    .pop        (pop),
    .reg_commit (reg_commit),
    .mem_store  (mem_store),
    .flush      (flush),
    .flush_pc   (flush_pc)
  );

endmodule

//--- design/commit_unit.sv
`timescale 1ns/100ps

module commit_unit import rob_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        head_valid,
  input  tag_t        head_tag,
  input  rob_entry_t  head_entry,
  input  logic        store_done,
  output logic        pop,
  output reg_commit_t reg_commit,
  output mem_store_t  mem_store,
  output logic        flush,
  output addr_t       flush_pc
);

  commit_state_t state;
  logic          is_store;
  logic          is_branch;
  logic          is_jalr;
  logic          writes_rd;
  logic          mispredict;
  mem_len_t      len;

  assign is_store   = head_entry.cls == op_store;
  assign is_branch  = head_entry.cls == op_branch;
  assign is_jalr    = head_entry.cls == op_jalr;
  assign writes_rd  = !is_store && !is_branch && (head_entry.rd != '0);
  // predicted taken, result bit 0 says whether it was
  assign mispredict = is_branch && !head_entry.result[0];

  // func3 mod 4, halfword-word gap closed so word is 3
  assign len = (head_entry.func3[1:0] == 2'd2) ? 2'd3 : head_entry.func3[1:0];

  // nothing retires in the flush cycle
  assign pop = head_valid && head_entry.ready && (state == commit_idle) && !flush;

  always_ff @(posedge clk) begin
    if (rst) begin
      state            <= commit_idle;
      flush            <= 1'b0;
      reg_commit.valid <= 1'b0;
      mem_store.valid  <= 1'b0;
    end else begin
      flush            <= 1'b0;
      reg_commit.valid <= 1'b0;
      mem_store.valid  <= 1'b0;
      if ((state == commit_storing) && store_done) begin
        state <= commit_idle;
      end
      if (pop) begin
        if (writes_rd) begin
          reg_commit.valid <= 1'b1;
          reg_commit.rd    <= head_entry.rd;
          reg_commit.tag   <= head_tag;
          reg_commit.value <= head_entry.result;
        end
        if (is_store) begin
          state           <= commit_storing;
          mem_store.valid <= 1'b1;
          mem_store.addr  <= head_entry.tar_addr;
          mem_store.len   <= len;
          mem_store.data  <= head_entry.result;
        end
        if (mispredict) begin
          flush    <= 1'b1;
          flush_pc <= head_entry.pc + 32'd4;
        end
        // jalr target is only known at execute, always redirect
        if (is_jalr) begin
          flush    <= 1'b1;
          flush_pc <= head_entry.tar_addr;
        end
      end
    end
  end

endmodule

//--- design/rob_store.sv
`timescale 1ns/100ps

module rob_store import rob_pkg::*; #(
  parameter int DEPTH = 8
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       alloc_valid,
  input  rob_entry_t alloc_entry,
  input  wb_t        wb,
  input  logic       pop,
  input  logic       flush,
  output logic       has_room,
  output issue_t     issue,
  output logic       head_valid,
  output tag_t       head_tag,
  output rob_entry_t head_entry
);

  localparam int PW = $clog2(DEPTH);

  rob_entry_t      entries [DEPTH];
  logic [PW-1:0]   head;
  logic [PW-1:0]   tail;
  logic [PW-1:0]   count;
  logic [PW-1:0]   wb_idx;
  logic            do_alloc;

  // at most DEPTH-1 entries, so the pointer difference never wraps
  assign count    = tail - head;
  assign has_room = (int'(count) + 1) < DEPTH;
  assign do_alloc = alloc_valid && !flush;
  assign wb_idx   = wb.tag[PW-1:0];

  assign head_valid = head != tail;
  assign head_tag   = tag_t'(head);
  assign head_entry = entries[head];

  always_ff @(posedge clk) begin
    if (rst) begin
      head        <= '0;
      tail        <= '0;
      issue.valid <= 1'b0;
    end else begin
      issue.valid <= 1'b0;
      if (flush) begin
        // tags restart at 0
        head <= '0;
        tail <= '0;
      end else begin
        if (pop) begin
          head <= head + 1'b1;
        end
        if (do_alloc) begin
          tail        <= tail + 1'b1;
          issue.valid <= 1'b1;
          issue.tag   <= tag_t'(tail);
          issue.cls   <= alloc_entry.cls;
          issue.rd    <= alloc_entry.rd;
          issue.pc    <= alloc_entry.pc;
        end
      end
    end
  end

  // entry array
  always_ff @(posedge clk) begin
    if (wb.valid) begin
      entries[wb_idx].result   <= wb.result;
      entries[wb_idx].tar_addr <= wb.tar_addr;
      entries[wb_idx].ready    <= 1'b1;
    end
    // new entry overrides a stray writeback to the same slot
    if (do_alloc) begin
      entries[tail] <= alloc_entry;
    end
  end

endmodule

//--- design/fetch_ctrl.sv
`timescale 1ns/100ps

module fetch_ctrl import rob_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       has_room,
  input  logic       flush,
  input  logic       fetch_valid,
  input  word_t      fetch_instr,
  input  addr_t      fetch_pc,
  input  logic       dec_valid,
  input  dec_resp_t  dec_resp,
  output logic       fetch_req,
  output logic       dec_req,
  output word_t      dec_instr,
  output logic       pc_write,
  output addr_t      pc_next,
  output logic       alloc_valid,
  output rob_entry_t alloc_entry
);

  fetch_state_t state;
  // pc of the instruction at the decoder
  addr_t        dec_pc;
  logic         take_imm;

  // static taken prediction for branches
  assign take_imm = (dec_resp.cls == op_jal) || (dec_resp.cls == op_branch);

  // decoder answer goes straight into the queue
  assign alloc_valid = (state == decode_wait) && dec_valid && !flush;

  always_comb begin
    alloc_entry          = '0;
    alloc_entry.cls      = dec_resp.cls;
    alloc_entry.rd       = dec_resp.rd;
    alloc_entry.func3    = dec_resp.func3;
    alloc_entry.imm      = dec_resp.imm;
    alloc_entry.pc       = dec_pc;
    alloc_entry.ready    = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= fetch_idle;
      fetch_req <= 1'b0;
      dec_req   <= 1'b0;
      pc_write  <= 1'b0;
    end else begin
      fetch_req <= 1'b0;
      dec_req   <= 1'b0;
      pc_write  <= 1'b0;
      if (flush) begin
        // drop whatever is in flight, late answers are ignored
        state <= fetch_idle;
      end else begin
        case (state)
          fetch_idle: begin
            if (has_room) begin
              fetch_req <= 1'b1;
              state     <= fetch_wait;
            end
          end
          fetch_wait: begin
            if (fetch_valid) begin
              dec_req <= 1'b1;
              state   <= decode_wait;
            end
          end
          decode_wait: begin
            if (dec_valid) begin
              pc_write <= 1'b1;
              state    <= fetch_idle;
            end
          end
          default: begin
            state <= fetch_idle;
          end
        endcase
      end
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if ((state == fetch_wait) && fetch_valid) begin
      dec_instr <= fetch_instr;
      dec_pc    <= fetch_pc;
    end
    if (alloc_valid) begin
      pc_next <= take_imm ? dec_pc + dec_resp.imm : dec_pc + 32'd4;
    end
  end

endmodule

//--- design/rob_pkg.sv
package rob_pkg;

  // widths with a meaning of their own
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [2:0]  func3_t;
  // wide enough for the largest queue of 16 entries
  typedef logic [3:0]  tag_t;
  // 0 byte, 1 halfword, 3 word
  typedef logic [1:0]  mem_len_t;

  typedef enum logic [2:0] {
    op_alu,
    op_load,
    op_store,
    op_branch,
    op_jal,
    op_jalr
  } op_class_t;

  typedef enum logic [1:0] {
    fetch_idle,
    fetch_wait,
    decode_wait
  } fetch_state_t;

  typedef enum logic {
    commit_idle,
    commit_storing
  } commit_state_t;

  // decoder answer
  typedef struct packed {
    op_class_t cls;
    reg_idx_t  rd;
    func3_t    func3;
    word_t     imm;
  } dec_resp_t;

  // one queue entry
  typedef struct packed {
    op_class_t cls;
    reg_idx_t  rd;
    func3_t    func3;
    word_t     imm;
    addr_t     pc;
    word_t     result;
    addr_t     tar_addr;
    logic      ready;
  } rob_entry_t;

  // merged writeback from the execution side
  typedef struct packed {
    logic  valid;
    tag_t  tag;
    word_t result;
    addr_t tar_addr;
  } wb_t;

  typedef struct packed {
    logic      valid;
    tag_t      tag;
    op_class_t cls;
    reg_idx_t  rd;
    addr_t     pc;
  } issue_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    tag_t     tag;
    word_t    value;
  } reg_commit_t;

  typedef struct packed {
    logic     valid;
    addr_t    addr;
    mem_len_t len;
    word_t    data;
  } mem_store_t;

endpackage
